// File: hw/activeList_defs.svh
`ifndef ACTIVELIST_DEFS_SVH
`define ACTIVELIST_DEFS_SVH

// list geometry
`define AL_SIZE         16
`define AL_ID_BITS      4

// datapath widths
`define PC_BITS         32
`define LOG_REG_BITS    5
`define PHY_REG_BITS    7

// per-cycle bandwidth of the front end, the commit stage and writeback
`define DISPATCH_WIDTH  4
`define COMMIT_WIDTH    4
`define FU_PORTS        2

`define TRAP_PC_STEP    8 // a trap restarts past its delay slot

`endif

// File: hw/activeListPkg.sv
`include "activeList_defs.svh"

package activeListPkg;

  typedef logic [`AL_ID_BITS-1:0]                  alId_t;
  typedef logic [`AL_ID_BITS:0]                    alCount_t; // one extra bit so a full list fits
  typedef logic [`PC_BITS-1:0]                     pc_t;
  typedef logic [$clog2(`DISPATCH_WIDTH+1)-1:0]    dispCount_t;
  typedef logic [`LOG_REG_BITS-1:0]                logReg_t;
  typedef logic [`PHY_REG_BITS-1:0]                phyReg_t;

  // one instruction as the rename stage hands it over
  typedef struct packed {
    logic    isLoad;
    logic    isStore;
    pc_t     pc;
    logReg_t logDest;
    phyReg_t phyDest;
    phyReg_t oldPhyDest; // freed once this instruction retires
    logic    hasDest;
  } alRecord_t;

  typedef struct packed {
    logic  valid;
    alId_t alId;
    logic  mispredict;
    logic  trap;
    pc_t   targetPc;
  } fuDone_t;

  typedef struct packed {
    logic    retire;
    logic    hasDest;
    logic    isStore;
    logic    isLoad;
    logReg_t logDest;
    phyReg_t phyDest;
    phyReg_t oldPhyDest;
  } commitSlot_t;

  // record plus completion state, as seen by the commit stage
  typedef struct packed {
    alRecord_t record;
    logic      done;
    logic      mispredict;
    logic      trap;
    pc_t       targetPc;
  } headEntry_t;

endpackage

// File: hw/alEntryStore.sv
`timescale 1ns/1ps
`include "activeList_defs.svh"

module alEntryStore (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       flush_i,
  input  logic                       dispatchValid_i,
  input  activeListPkg::dispCount_t  dispatchCount_i,
  input  activeListPkg::alId_t       tail_i,
  input  activeListPkg::alRecord_t   record_i [`DISPATCH_WIDTH],
  input  activeListPkg::fuDone_t     fuDone_i [`FU_PORTS],
  input  activeListPkg::alId_t       head_i,
  output activeListPkg::headEntry_t  headEntry_o [`COMMIT_WIDTH]
);

  activeListPkg::alRecord_t recordMem [`AL_SIZE];
  activeListPkg::pc_t       targetMem [`AL_SIZE];
  logic [`AL_SIZE-1:0]      mispredMem;
  logic [`AL_SIZE-1:0]      trapMem;
  logic [`AL_SIZE-1:0]      doneBits;

  logic [`DISPATCH_WIDTH-1:0] writeEn;
  activeListPkg::alId_t       writeAddr [`DISPATCH_WIDTH];
  activeListPkg::alId_t       readAddr [`COMMIT_WIDTH];

  // slot i of the dispatch group is live when it lies below the count
  always_comb
  begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++)
    begin
      writeAddr[i] = tail_i + activeListPkg::alId_t'(i); // wraps around the list
      writeEn[i]   = dispatchValid_i && !flush_i &&
                     (dispatchCount_i > activeListPkg::dispCount_t'(i));
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++)
    begin
      if (writeEn[i])
        recordMem[writeAddr[i]] <= record_i[i];
    end
    for (int p = 0; p < `FU_PORTS; p++)
    begin
      if (fuDone_i[p].valid)
      begin
        targetMem[fuDone_i[p].alId]  <= fuDone_i[p].targetPc;
        mispredMem[fuDone_i[p].alId] <= fuDone_i[p].mispredict;
        trapMem[fuDone_i[p].alId]    <= fuDone_i[p].trap;
      end
    end
  end

  // new entries start not done; completions to older entries still land this cycle
  always_ff @(posedge clk)
  begin
    if (reset || flush_i)
      doneBits <= '0;
    else
    begin
      for (int i = 0; i < `DISPATCH_WIDTH; i++)
      begin
        if (writeEn[i])
          doneBits[writeAddr[i]] <= 1'b0;
      end
      for (int p = 0; p < `FU_PORTS; p++)
      begin
        if (fuDone_i[p].valid)
          doneBits[fuDone_i[p].alId] <= 1'b1;
      end
    end
  end

  always_comb
  begin
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      readAddr[i]    = head_i + activeListPkg::alId_t'(i);
      headEntry_o[i] = '{record:     recordMem[readAddr[i]],
                         done:       doneBits[readAddr[i]],
                         mispredict: mispredMem[readAddr[i]],
                         trap:       trapMem[readAddr[i]],
                         targetPc:   targetMem[readAddr[i]]};
    end
  end

  // each instruction executes on one unit only, so two ports never report the same entry
  assert property (@(posedge clk) disable iff (reset)
    !(fuDone_i[0].valid && fuDone_i[1].valid && (fuDone_i[0].alId == fuDone_i[1].alId)));

endmodule

// File: hw/alCommitSelect.sv
`timescale 1ns/1ps
`include "activeList_defs.svh"

module alCommitSelect (
  input  activeListPkg::headEntry_t   headEntry_i [`COMMIT_WIDTH],
  input  activeListPkg::alCount_t     count_i,
  input  logic                        flush_i,
  output activeListPkg::commitSlot_t  commitSlot_o [`COMMIT_WIDTH],
  output activeListPkg::dispCount_t   commitNum_o,
  output logic                        mispredEvent_o,
  output logic                        trapEvent_o,
  output activeListPkg::pc_t          headPc_o,
  output activeListPkg::pc_t          headTarget_o
);

  logic [`COMMIT_WIDTH-1:0] canRetire;
  logic [`COMMIT_WIDTH-1:0] retireRun;
  logic                     headValid;

  assign headValid = (count_i != '0) && !flush_i;

  // per-slot eligibility, independent of the slots before it
  always_comb
  begin
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      canRetire[i] = (count_i > activeListPkg::alCount_t'(i)) &&
                     headEntry_i[i].done && !headEntry_i[i].trap;
      // a mispredicted branch must be the last one of its group, and only at the head
      if ((i > 0) && (headEntry_i[i].mispredict || headEntry_i[0].mispredict))
        canRetire[i] = 1'b0;
    end
  end

  // only the leading run retires, so the group stays in program order
  always_comb
  begin
    logic runOk;
    runOk       = !flush_i;
    commitNum_o = '0;
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      runOk        = runOk && canRetire[i];
      retireRun[i] = runOk;
      if (runOk)
        commitNum_o = commitNum_o + activeListPkg::dispCount_t'(1);
    end
  end

  always_comb
  begin
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      commitSlot_o[i] = '0; // slots outside the run stay all zero
      if (retireRun[i])
      begin
        commitSlot_o[i].retire     = 1'b1;
        commitSlot_o[i].hasDest    = headEntry_i[i].record.hasDest;
        commitSlot_o[i].isStore    = headEntry_i[i].record.isStore;
        commitSlot_o[i].isLoad     = headEntry_i[i].record.isLoad;
        commitSlot_o[i].logDest    = headEntry_i[i].record.logDest;
        commitSlot_o[i].phyDest    = headEntry_i[i].record.phyDest;
        commitSlot_o[i].oldPhyDest = headEntry_i[i].record.oldPhyDest;
      end
    end
  end

  // the branch itself commits and recovery follows in the next cycle
  assign mispredEvent_o = retireRun[0] && headEntry_i[0].mispredict;

  // a trap never commits, it only raises the event once it is done at the head
  assign trapEvent_o = headValid && headEntry_i[0].done && headEntry_i[0].trap;

  assign headPc_o     = headEntry_i[0].record.pc;
  assign headTarget_o = headEntry_i[0].targetPc;

endmodule

// File: hw/alPointerCtrl.sv
`timescale 1ns/1ps
`include "activeList_defs.svh"

module alPointerCtrl (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       dispatchValid_i,
  input  activeListPkg::dispCount_t  dispatchCount_i,
  input  activeListPkg::dispCount_t  commitNum_i,
  input  logic                       mispredEvent_i,
  input  logic                       trapEvent_i,
  input  activeListPkg::pc_t         headPc_i,
  input  activeListPkg::pc_t         headTarget_i,
  output activeListPkg::alId_t       head_o,
  output activeListPkg::alId_t       tail_o,
  output activeListPkg::alCount_t    count_o,
  output logic                       flush_o,
  output logic                       recoverFlag_o,
  output activeListPkg::pc_t         recoverPc_o,
  output logic                       trapFlag_o,
  output activeListPkg::pc_t         trapPc_o
);

  activeListPkg::alCount_t countNext;

  // either flag empties the whole list at the end of its cycle
  assign flush_o = recoverFlag_o || trapFlag_o;

  always_comb
  begin
    countNext = count_o - activeListPkg::alCount_t'(commitNum_i);
    if (dispatchValid_i)
      countNext = countNext + activeListPkg::alCount_t'(dispatchCount_i);
  end

  always_ff @(posedge clk)
  begin
    if (reset || flush_o)
    begin
      head_o  <= '0;
      tail_o  <= '0;
      count_o <= '0;
    end
    else
    begin
      head_o <= head_o + activeListPkg::alId_t'(commitNum_i);
      if (dispatchValid_i)
        tail_o <= tail_o + activeListPkg::alId_t'(dispatchCount_i);
      count_o <= countNext;
    end
  end

  // each flag is a single-cycle pulse since it triggers its own flush
  always_ff @(posedge clk)
  begin
    if (reset || flush_o)
    begin
      recoverFlag_o <= 1'b0;
      trapFlag_o    <= 1'b0;
    end
    else
    begin
      recoverFlag_o <= mispredEvent_i;
      trapFlag_o    <= trapEvent_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (mispredEvent_i)
      recoverPc_o <= headTarget_i; // fetch resumes on the resolved path
    if (trapEvent_i)
      trapPc_o <= headPc_i + activeListPkg::pc_t'(`TRAP_PC_STEP);
  end

  // the front end gets no full signal, so a dispatch must never overrun the list
  assert property (@(posedge clk) disable iff (reset)
    (dispatchValid_i && !flush_o) |=> (count_o <= `AL_SIZE));

  assert property (@(posedge clk) disable iff (reset)
    !(recoverFlag_o && trapFlag_o));

endmodule

// File: hw/activeList.sv
`timescale 1ns/1ps
`include "activeList_defs.svh"

module activeList (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        dispatchValid_i,
  input  activeListPkg::dispCount_t   dispatchCount_i,
  input  activeListPkg::alRecord_t    dispatchRecord_i [`DISPATCH_WIDTH],
  output activeListPkg::alId_t        alId_o [`DISPATCH_WIDTH],
  input  activeListPkg::fuDone_t      fuDone_i [`FU_PORTS],
  output activeListPkg::alCount_t     count_o,
  output activeListPkg::commitSlot_t  commitSlot_o [`COMMIT_WIDTH],
  output logic                        recoverFlag_o,
  output activeListPkg::pc_t          recoverPc_o,
  output logic                        trapFlag_o,
  output activeListPkg::pc_t          trapPc_o
);

  activeListPkg::alId_t       head;
  activeListPkg::alId_t       tail;
  logic                       flush;
  activeListPkg::headEntry_t  headEntry [`COMMIT_WIDTH];
  activeListPkg::dispCount_t  commitNum;
  logic                       mispredEvent;
  logic                       trapEvent;
  activeListPkg::pc_t         headPc;
  activeListPkg::pc_t         headTarget;

  // rename tags each instruction with the slot it will occupy
  always_comb
  begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++)
      alId_o[i] = tail + activeListPkg::alId_t'(i);
  end

  alEntryStore entryStore (
    .clk             (clk),
    .reset           (reset),
    .flush_i         (flush),
    .dispatchValid_i (dispatchValid_i),
    .dispatchCount_i (dispatchCount_i),
    .tail_i          (tail),
    .record_i        (dispatchRecord_i),
    .fuDone_i        (fuDone_i),
    .head_i          (head),
    .headEntry_o     (headEntry)
  );

  alCommitSelect commitSelect (
    .headEntry_i    (headEntry),
    .count_i        (count_o),
    .flush_i        (flush),
    .commitSlot_o   (commitSlot_o),
    .commitNum_o    (commitNum),
    .mispredEvent_o (mispredEvent),
    .trapEvent_o    (trapEvent),
    .headPc_o       (headPc),
    .headTarget_o   (headTarget)
  );

  alPointerCtrl pointerCtrl (
    .clk             (clk),
    .reset           (reset),
    .dispatchValid_i (dispatchValid_i),
    .dispatchCount_i (dispatchCount_i),
    .commitNum_i     (commitNum),
    .mispredEvent_i  (mispredEvent),
    .trapEvent_i     (trapEvent),
    .headPc_i        (headPc),
    .headTarget_i    (headTarget),
    .head_o          (head),
    .tail_o          (tail),
    .count_o         (count_o),
    .flush_o         (flush),
    .recoverFlag_o   (recoverFlag_o),
    .recoverPc_o     (recoverPc_o),
    .trapFlag_o      (trapFlag_o),
    .trapPc_o        (trapPc_o)
  );

endmodule

// File: bench/alClockGen.sv
`timescale 1ns/1ps

module alClockGen (
  output logic clk_o,
  output logic reset_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o; // 4 ns period
  end

  initial
  begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// File: bench/activeListTb.sv
`timescale 1ns/1ps
`include "activeList_defs.svh"

module activeListTb;

  localparam int CYCLE_LIMIT = 400; // the directed tests need on the order of 100 cycles

  logic                        clk;
  logic                        reset;
  logic                        dispatchValid;
  activeListPkg::dispCount_t   dispatchCount;
  activeListPkg::alRecord_t    dispatchRecord [`DISPATCH_WIDTH];
  activeListPkg::alId_t        alId [`DISPATCH_WIDTH];
  activeListPkg::fuDone_t      fuDone [`FU_PORTS];
  activeListPkg::alCount_t     count;
  activeListPkg::commitSlot_t  commitSlot [`COMMIT_WIDTH];
  logic                        recoverFlag;
  activeListPkg::pc_t          recoverPc;
  logic                        trapFlag;
  activeListPkg::pc_t          trapPc;

  // reference state kept from the dispatch and commit rules
  activeListPkg::alRecord_t    refRec [`AL_SIZE];
  activeListPkg::alId_t        modelHead;
  activeListPkg::alId_t        modelTail;
  activeListPkg::alCount_t     modelCount;
  int                          cycleCount = 0;

  alClockGen clockGen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  activeList dut (
    .clk              (clk),
    .reset            (reset),
    .dispatchValid_i  (dispatchValid),
    .dispatchCount_i  (dispatchCount),
    .dispatchRecord_i (dispatchRecord),
    .alId_o           (alId),
    .fuDone_i         (fuDone),
    .count_o          (count),
    .commitSlot_o     (commitSlot),
    .recoverFlag_o    (recoverFlag),
    .recoverPc_o      (recoverPc),
    .trapFlag_o       (trapFlag),
    .trapPc_o         (trapPc)
  );

  task automatic stopRun();
    $display("Testbench failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("Mismatch %s: got %h, expected %h", name, actual, expected);
      stopRun();
    end
  endtask

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      stopRun();
    end
  end

  function automatic activeListPkg::alRecord_t randomRecord();
    activeListPkg::alRecord_t rec;
    rec.isLoad     = 1'($urandom);
    rec.isStore    = 1'($urandom);
    rec.pc         = $urandom;
    rec.logDest    = activeListPkg::logReg_t'($urandom);
    rec.phyDest    = activeListPkg::phyReg_t'($urandom);
    rec.oldPhyDest = activeListPkg::phyReg_t'($urandom);
    rec.hasDest    = 1'($urandom);
    return rec;
  endfunction

  // a retiring slot carries the register and memory fields of its record
  function automatic activeListPkg::commitSlot_t expectedSlot(activeListPkg::alRecord_t rec);
    activeListPkg::commitSlot_t slot;
    slot.retire     = 1'b1;
    slot.hasDest    = rec.hasDest;
    slot.isStore    = rec.isStore;
    slot.isLoad     = rec.isLoad;
    slot.logDest    = rec.logDest;
    slot.phyDest    = rec.phyDest;
    slot.oldPhyDest = rec.oldPhyDest;
    return slot;
  endfunction

  function automatic activeListPkg::fuDone_t report(activeListPkg::alId_t id, logic mispredict,
                                                    logic trap, activeListPkg::pc_t target);
    activeListPkg::fuDone_t rep;
    rep.valid      = 1'b1;
    rep.alId       = id;
    rep.mispredict = mispredict;
    rep.trap       = trap;
    rep.targetPc   = target;
    return rep;
  endfunction

  // ends in the cycle after the edge that takes the reports
  task automatic writeback(input activeListPkg::fuDone_t rep0, input activeListPkg::fuDone_t rep1);
    @(posedge clk);
    fuDone[0] <= rep0;
    fuDone[1] <= rep1;
    @(posedge clk);
    fuDone[0] <= '0;
    fuDone[1] <= '0;
    @(negedge clk);
  endtask

  task automatic completePair(input activeListPkg::alId_t id0, input activeListPkg::alId_t id1);
    writeback(report(id0, 1'b0, 1'b0, $urandom), report(id1, 1'b0, 1'b0, $urandom));
  endtask

  task automatic dispatchGroup(input int n);
    activeListPkg::alRecord_t rec;
    activeListPkg::alId_t     wantId;
    @(posedge clk);
    dispatchValid <= 1'b1;
    dispatchCount <= activeListPkg::dispCount_t'(n);
    for (int i = 0; i < `DISPATCH_WIDTH; i++)
    begin
      rec = randomRecord();
      dispatchRecord[i] <= rec;
      if (i < n)
        refRec[modelTail + activeListPkg::alId_t'(i)] = rec;
    end
    @(negedge clk);
    for (int i = 0; i < n; i++)
    begin
      wantId = modelTail + activeListPkg::alId_t'(i);
      checkValue($sformatf("alId[%0d]", i), 64'(alId[i]), 64'(wantId));
    end
    @(posedge clk);
    dispatchValid <= 1'b0;
    modelTail  = modelTail + activeListPkg::alId_t'(n);
    modelCount = modelCount + activeListPkg::alCount_t'(n);
    @(negedge clk);
    checkValue("count", 64'(count), 64'(modelCount));
  endtask

  // slots below n retire the oldest records in order, the rest stay zero
  task automatic checkSlots(input int n);
    activeListPkg::commitSlot_t want;
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      if (i < n)
        want = expectedSlot(refRec[modelHead + activeListPkg::alId_t'(i)]);
      else
        want = '0;
      checkValue($sformatf("commitSlot[%0d]", i), 64'(commitSlot[i]), 64'(want));
    end
    modelHead  = modelHead + activeListPkg::alId_t'(n);
    modelCount = modelCount - activeListPkg::alCount_t'(n);
  endtask

  task automatic expectCommit(input int n);
    checkSlots(n);
    checkValue("recoverFlag", 64'(recoverFlag), 64'(1'b0));
    @(posedge clk);
    @(negedge clk);
    checkValue("count", 64'(count), 64'(modelCount));
  endtask

  task automatic resetState();
    checkValue("count", 64'(count), 64'(0));
    checkValue("recoverFlag", 64'(recoverFlag), 64'(1'b0));
    checkValue("trapFlag", 64'(trapFlag), 64'(1'b0));
    checkSlots(0);
  endtask

  task automatic dispatchIds();
    dispatchGroup(3);
    dispatchGroup(4);
  endtask

  task automatic outOfOrderCompletion();
    completePair(4'd6, 4'd5);
    completePair(4'd4, 4'd3);
    checkSlots(0); // head still waits
    completePair(4'd2, 4'd0);
    expectCommit(1); // entry 1 is not done yet
    writeback(report(4'd1, 1'b0, 1'b0, $urandom), '0);
    expectCommit(4);
    expectCommit(2);
  endtask

  task automatic wrapDrain();
    dispatchGroup(4);
    dispatchGroup(4);
    dispatchGroup(4);
    dispatchGroup(2);
    completePair(4'd4, 4'd3);
    completePair(4'd2, 4'd1);
    completePair(4'd0, 4'd15);
    completePair(4'd14, 4'd13);
    completePair(4'd12, 4'd11);
    completePair(4'd10, 4'd9);
    completePair(4'd8, 4'd7);
    expectCommit(4);
    expectCommit(4);
    expectCommit(4);
    expectCommit(2);
  endtask

  task automatic mispredictRecovery();
    activeListPkg::pc_t target;
    target = $urandom;
    dispatchGroup(3);
    completePair(modelHead + 4'd2, modelHead + 4'd1);
    writeback(report(modelHead, 1'b1, 1'b0, target), '0);
    checkSlots(1); // the branch retires alone
    checkValue("recoverFlag", 64'(recoverFlag), 64'(1'b0));
    @(posedge clk);
    dispatchValid <= 1'b1; // must be dropped during the flush
    dispatchCount <= activeListPkg::dispCount_t'(2);
    @(negedge clk);
    checkValue("recoverFlag", 64'(recoverFlag), 64'(1'b1));
    checkValue("recoverPc", 64'(recoverPc), 64'(target));
    checkSlots(0);
    @(posedge clk);
    dispatchValid <= 1'b0;
    @(negedge clk);
    checkValue("count", 64'(count), 64'(0));
    checkValue("recoverFlag", 64'(recoverFlag), 64'(1'b0));
    modelHead  = '0;
    modelTail  = '0;
    modelCount = '0;
  endtask

  task automatic trapRecovery();
    activeListPkg::pc_t restartPc;
    dispatchGroup(2);
    writeback(report(modelHead + 4'd1, 1'b0, 1'b0, $urandom), '0);
    writeback(report(modelHead, 1'b0, 1'b1, $urandom), '0);
    checkSlots(0);
    checkValue("trapFlag", 64'(trapFlag), 64'(1'b0));
    restartPc = refRec[modelHead].pc + `TRAP_PC_STEP;
    @(posedge clk);
    @(negedge clk);
    checkValue("trapFlag", 64'(trapFlag), 64'(1'b1));
    checkValue("trapPc", 64'(trapPc), 64'(restartPc));
    checkSlots(0);
    @(posedge clk);
    @(negedge clk);
    checkValue("count", 64'(count), 64'(0));
    checkValue("trapFlag", 64'(trapFlag), 64'(1'b0));
  endtask

  initial
  begin
    void'($urandom(32'hca84));
    dispatchValid = 1'b0;
    dispatchCount = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++)
      dispatchRecord[i] = '0;
    for (int p = 0; p < `FU_PORTS; p++)
      fuDone[p] = '0;
    modelHead  = '0;
    modelTail  = '0;
    modelCount = '0;
    @(negedge reset);
    @(negedge clk);
    resetState();
    dispatchIds();
    outOfOrderCompletion();
    wrapDrain();
    mispredictRecovery();
    trapRecovery();
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: src.f
+incdir+hw
hw/activeListPkg.sv
hw/alEntryStore.sv
hw/alCommitSelect.sv
hw/alPointerCtrl.sv
hw/activeList.sv
bench/alClockGen.sv
bench/activeListTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the active list testbench with Verilator and run it.
# The simulator's exit status carries pass or fail.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f \
  --top-module activeListTb \
  -o simActiveList

./obj_dir/simActiveList
